// ==== rtl/a2_card_defines.svh ====
// Widths, audio placement shifts and the default audio rate divider
// for the slot-card response and audio mix logic.
// Include wherever one of these values is needed.

`ifndef A2_CARD_DEFINES_SVH
`define A2_CARD_DEFINES_SVH

// Apple bus data byte
`define A2_DATA_W 8

// Sprite and Mockingboard audio levels, unsigned
`define CARD_AUDIO_W 10

// GLU audio and the mixed sample, signed
`define MIX_W 16

// Where the smaller sources land inside the 16-bit mix
`define CARD_AUDIO_SHIFT 3
`define SPEAKER_SHIFT 12

// Clock cycles per output sample
`define AUDIO_DIV_DEFAULT 16

`endif

// ==== rtl/a2_card_pkg.sv ====
// Shared data, audio and sample types for the card logic.
// Referenced by scoped names from the interfaces and RTL modules.

`include "a2_card_defines.svh"

package a2_card_pkg;

    // One byte on the Apple bus data lines
    typedef logic [`A2_DATA_W-1:0] a2_data_t;

    // Unsigned level from the sprite card or the Mockingboard
    typedef logic [`CARD_AUDIO_W-1:0] card_audio_t;

    // Signed audio value, GLU input and mixed output alike
    typedef logic signed [`MIX_W-1:0] mix_sample_t;

    // Left and right channels of one mixed sample
    typedef struct packed {
        mix_sample_t l;
        mix_sample_t r;
    } stereo_sample_t;

endpackage

// ==== rtl/a2_card_ifs.sv ====
// Interfaces between the input registers and the processing blocks.
// card_bus_if carries the per-card bus response, audio_src_if the raw
// audio sources. Both are driven through src and read through dst.

`timescale 1ns/1ns

interface card_bus_if;

    // Serial card
    logic                  ssc_rd;
    a2_card_pkg::a2_data_t ssc_data;
    logic                  ssc_irq_n;

    // Sprite/video card
    logic                  ssp_rd;
    a2_card_pkg::a2_data_t ssp_data;
    logic                  ssp_irq_n;

    // Mockingboard
    logic                  mb_rd;
    a2_card_pkg::a2_data_t mb_data;
    logic                  mb_irq_n;

    // Byte already on the bus when no card answers
    a2_card_pkg::a2_data_t bus_data;

    modport src (
        output ssc_rd, ssc_data, ssc_irq_n,
        output ssp_rd, ssp_data, ssp_irq_n,
        output mb_rd, mb_data, mb_irq_n,
        output bus_data
    );

    modport dst (
        input ssc_rd, ssc_data, ssc_irq_n,
        input ssp_rd, ssp_data, ssp_irq_n,
        input mb_rd, mb_data, mb_irq_n,
        input bus_data
    );

endinterface

interface audio_src_if;

    logic                     speaker;
    a2_card_pkg::card_audio_t ssp_audio;
    a2_card_pkg::card_audio_t mb_audio_l;
    a2_card_pkg::card_audio_t mb_audio_r;
    a2_card_pkg::mix_sample_t glu_audio_l;
    a2_card_pkg::mix_sample_t glu_audio_r;

    modport src (output speaker, ssp_audio, mb_audio_l, mb_audio_r, glu_audio_l, glu_audio_r);
    modport dst (input speaker, ssp_audio, mb_audio_l, mb_audio_r, glu_audio_l, glu_audio_r);

endinterface

// ==== rtl/card_input_regs.sv ====
// Input stage. Registers every card and audio input once so the bus
// mux and the audio mixer each see one clean sample per clock.

`timescale 1ns/1ns

module card_input_regs (
    input  logic                     a2bus_if,
    input  logic                     rst_n_i,

    input  a2_card_pkg::a2_data_t    bus_data_i,

    input  logic                     ssc_rd_i,
    input  a2_card_pkg::a2_data_t    ssc_data_i,
    input  logic                     ssc_irq_n_i,
    input  logic                     ssp_rd_i,
    input  a2_card_pkg::a2_data_t    ssp_data_i,
    input  logic                     ssp_irq_n_i,
    input  logic                     mb_rd_i,
    input  a2_card_pkg::a2_data_t    mb_data_i,
    input  logic                     mb_irq_n_i,

    input  logic                     speaker_i,
    input  a2_card_pkg::card_audio_t ssp_audio_i,
    input  a2_card_pkg::card_audio_t mb_audio_l_i,
    input  a2_card_pkg::card_audio_t mb_audio_r_i,
    input  a2_card_pkg::mix_sample_t glu_audio_l_i,
    input  a2_card_pkg::mix_sample_t glu_audio_r_i,

    card_bus_if.src                  card_bus_o,
    audio_src_if.src                 audio_src_o
);

    // Card side of the bus, irq lines idle high
    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            card_bus_o.ssc_rd    <= 1'b0;
            card_bus_o.ssc_data  <= '0;
            card_bus_o.ssc_irq_n <= 1'b1;
            card_bus_o.ssp_rd    <= 1'b0;
            card_bus_o.ssp_data  <= '0;
            card_bus_o.ssp_irq_n <= 1'b1;
            card_bus_o.mb_rd     <= 1'b0;
            card_bus_o.mb_data   <= '0;
            card_bus_o.mb_irq_n  <= 1'b1;
            card_bus_o.bus_data  <= '0;
        end else begin
            card_bus_o.ssc_rd    <= ssc_rd_i;
            card_bus_o.ssc_data  <= ssc_data_i;
            card_bus_o.ssc_irq_n <= ssc_irq_n_i;
            card_bus_o.ssp_rd    <= ssp_rd_i;
            card_bus_o.ssp_data  <= ssp_data_i;
            card_bus_o.ssp_irq_n <= ssp_irq_n_i;
            card_bus_o.mb_rd     <= mb_rd_i;
            card_bus_o.mb_data   <= mb_data_i;
            card_bus_o.mb_irq_n  <= mb_irq_n_i;
            card_bus_o.bus_data  <= bus_data_i;
        end
    end

    // Audio sources
    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            audio_src_o.speaker     <= 1'b0;
            audio_src_o.ssp_audio   <= '0;
            audio_src_o.mb_audio_l  <= '0;
            audio_src_o.mb_audio_r  <= '0;
            audio_src_o.glu_audio_l <= '0;
            audio_src_o.glu_audio_r <= '0;
        end else begin
            audio_src_o.speaker     <= speaker_i;
            audio_src_o.ssp_audio   <= ssp_audio_i;
            audio_src_o.mb_audio_l  <= mb_audio_l_i;
            audio_src_o.mb_audio_r  <= mb_audio_r_i;
            audio_src_o.glu_audio_l <= glu_audio_l_i;
            audio_src_o.glu_audio_r <= glu_audio_r_i;
        end
    end

endmodule

// ==== rtl/bus_response_mux.sv ====
// Bus response. Picks which card drives the Apple data bus, serial card
// first, then sprite card, then Mockingboard, and wire-ANDs the irq lines.
// All three results are registered.

`timescale 1ns/1ns

module bus_response_mux (
    input  logic                  a2bus_if,
    input  logic                  rst_n_i,

    card_bus_if.dst               card_bus_i,

    output a2_card_pkg::a2_data_t data_out_o,
    output logic                  data_out_en_o,
    output logic                  irq_n_o
);

    a2_card_pkg::a2_data_t data_sel;
    logic                  any_rd;
    logic                  irq_n_all;

    // Priority select, passthrough when nobody reads
    always_comb begin
        if (card_bus_i.ssc_rd) begin
            data_sel = card_bus_i.ssc_data;
        end else if (card_bus_i.ssp_rd) begin
            data_sel = card_bus_i.ssp_data;
        end else if (card_bus_i.mb_rd) begin
            data_sel = card_bus_i.mb_data;
        end else begin
            data_sel = card_bus_i.bus_data;
        end
    end

    assign any_rd = card_bus_i.ssc_rd | card_bus_i.ssp_rd | card_bus_i.mb_rd;

    // Any card pulling low pulls the shared line low
    assign irq_n_all = card_bus_i.ssc_irq_n & card_bus_i.ssp_irq_n & card_bus_i.mb_irq_n;

    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_out_o    <= '0;
            data_out_en_o <= 1'b0;
            irq_n_o       <= 1'b1;
        end else begin
            data_out_o    <= data_sel;
            data_out_en_o <= any_rd;
            irq_n_o       <= irq_n_all;
        end
    end

endmodule

// ==== rtl/audio_mixer.sv ====
// Audio mixer. Places the speaker bit and the 10-bit card audio inside
// the 16-bit range and adds them to the GLU channels. The sum wraps at
// 16 bits and is registered once per clock.

`timescale 1ns/1ns

`include "a2_card_defines.svh"

module audio_mixer (
    input  logic                        a2bus_if,
    input  logic                        rst_n_i,

    audio_src_if.dst                    audio_src_i,

    output a2_card_pkg::stereo_sample_t mix_o
);

    logic [`MIX_W-1:0] speaker_ext;
    logic [`MIX_W-1:0] ssp_ext;
    logic [`MIX_W-1:0] mb_l_ext;
    logic [`MIX_W-1:0] mb_r_ext;
    logic [`MIX_W-1:0] sum_l;
    logic [`MIX_W-1:0] sum_r;

    // Unsigned sources, zero-extended before the shift
    assign speaker_ext = `MIX_W'(audio_src_i.speaker) << `SPEAKER_SHIFT;
    assign ssp_ext     = `MIX_W'(audio_src_i.ssp_audio) << `CARD_AUDIO_SHIFT;
    assign mb_l_ext    = `MIX_W'(audio_src_i.mb_audio_l) << `CARD_AUDIO_SHIFT;
    assign mb_r_ext    = `MIX_W'(audio_src_i.mb_audio_r) << `CARD_AUDIO_SHIFT;

    // Sprite audio and speaker are mono and go to both sides
    assign sum_l = audio_src_i.glu_audio_l + ssp_ext + mb_l_ext + speaker_ext;
    assign sum_r = audio_src_i.glu_audio_r + ssp_ext + mb_r_ext + speaker_ext;

    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mix_o <= '0;
        end else begin
            mix_o.l <= a2_card_pkg::mix_sample_t'(sum_l);
            mix_o.r <= a2_card_pkg::mix_sample_t'(sum_r);
        end
    end

endmodule

// ==== rtl/audio_sample_out.sv ====
// Audio output stage. A period counter running from reset sets the
// sample rate; at each wrap the current mix is held on the outputs and
// sample_valid_o is high for one clock. Unread samples are overwritten.

`timescale 1ns/1ns

`include "a2_card_defines.svh"

module audio_sample_out #(
    parameter int AUDIO_DIV = `AUDIO_DIV_DEFAULT
) (
    input  logic                        a2bus_if,
    input  logic                        rst_n_i,

    input  a2_card_pkg::stereo_sample_t mix_i,

    output a2_card_pkg::mix_sample_t    sample_l_o,
    output a2_card_pkg::mix_sample_t    sample_r_o,
    output logic                        sample_valid_o
);

    localparam int CNT_W = (AUDIO_DIV > 1) ? $clog2(AUDIO_DIV) : 1;

    logic [CNT_W-1:0] period_cnt;
    logic             period_wrap;

    assign period_wrap = (period_cnt == CNT_W'(AUDIO_DIV - 1));

    // Cycle counter within one audio period
    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            period_cnt <= '0;
        end else if (period_wrap) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // Capture on wrap, valid for exactly one cycle
    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sample_l_o     <= '0;
            sample_r_o     <= '0;
            sample_valid_o <= 1'b0;
        end else begin
            sample_valid_o <= period_wrap;
            if (period_wrap) begin
                sample_l_o <= mix_i.l;
                sample_r_o <= mix_i.r;
            end
        end
    end

endmodule

// ==== rtl/a2_card_top.sv ====
// Slot-card response and audio mix top level. Card bus outputs follow
// the inputs by 2 clocks; each valid audio sample reflects the inputs
// from 3 clocks before the pulse. AUDIO_DIV sets clocks per sample.

`timescale 1ns/1ns

`include "a2_card_defines.svh"

module a2_card_top #(
    parameter int AUDIO_DIV = `AUDIO_DIV_DEFAULT
) (
    input  logic                     a2bus_if,
    input  logic                     rst_n_i,

    input  a2_card_pkg::a2_data_t    bus_data_i,

    // Serial card
    input  logic                     ssc_rd_i,
    input  a2_card_pkg::a2_data_t    ssc_data_i,
    input  logic                     ssc_irq_n_i,

    // Sprite/video card
    input  logic                     ssp_rd_i,
    input  a2_card_pkg::a2_data_t    ssp_data_i,
    input  logic                     ssp_irq_n_i,

    // Mockingboard
    input  logic                     mb_rd_i,
    input  a2_card_pkg::a2_data_t    mb_data_i,
    input  logic                     mb_irq_n_i,

    // Audio sources
    input  logic                     speaker_i,
    input  a2_card_pkg::card_audio_t ssp_audio_i,
    input  a2_card_pkg::card_audio_t mb_audio_l_i,
    input  a2_card_pkg::card_audio_t mb_audio_r_i,
    input  a2_card_pkg::mix_sample_t glu_audio_l_i,
    input  a2_card_pkg::mix_sample_t glu_audio_r_i,

    // Bus response
    output a2_card_pkg::a2_data_t    data_out_o,
    output logic                     data_out_en_o,
    output logic                     irq_n_o,

    // Audio out
    output a2_card_pkg::mix_sample_t sample_l_o,
    output a2_card_pkg::mix_sample_t sample_r_o,
    output logic                     sample_valid_o
);

    card_bus_if  card_bus ();
    audio_src_if audio_src ();

    a2_card_pkg::stereo_sample_t mix;

    card_input_regs card_input_regs_inst (
        .a2bus_if      (a2bus_if),
        .rst_n_i       (rst_n_i),
        .bus_data_i    (bus_data_i),
        .ssc_rd_i      (ssc_rd_i),
        .ssc_data_i    (ssc_data_i),
        .ssc_irq_n_i   (ssc_irq_n_i),
        .ssp_rd_i      (ssp_rd_i),
        .ssp_data_i    (ssp_data_i),
        .ssp_irq_n_i   (ssp_irq_n_i),
        .mb_rd_i       (mb_rd_i),
        .mb_data_i     (mb_data_i),
        .mb_irq_n_i    (mb_irq_n_i),
        .speaker_i     (speaker_i),
        .ssp_audio_i   (ssp_audio_i),
        .mb_audio_l_i  (mb_audio_l_i),
        .mb_audio_r_i  (mb_audio_r_i),
        .glu_audio_l_i (glu_audio_l_i),
        .glu_audio_r_i (glu_audio_r_i),
        .card_bus_o    (card_bus),
        .audio_src_o   (audio_src)
    );

    bus_response_mux bus_response_mux_inst (
        .a2bus_if      (a2bus_if),
        .rst_n_i       (rst_n_i),
        .card_bus_i    (card_bus),
        .data_out_o    (data_out_o),
        .data_out_en_o (data_out_en_o),
        .irq_n_o       (irq_n_o)
    );

    audio_mixer audio_mixer_inst (
        .a2bus_if    (a2bus_if),
        .rst_n_i     (rst_n_i),
        .audio_src_i (audio_src),
        .mix_o       (mix)
    );

    audio_sample_out #(
        .AUDIO_DIV(AUDIO_DIV)
    ) audio_sample_out_inst (
        .a2bus_if       (a2bus_if),
        .rst_n_i        (rst_n_i),
        .mix_i          (mix),
        .sample_l_o     (sample_l_o),
        .sample_r_o     (sample_r_o),
        .sample_valid_o (sample_valid_o)
    );

endmodule

// ==== tests/tb_a2_card_top.sv ====
// Self-checking testbench for a2_card_top. Reads one pattern per line
// from tests/card_mix_patterns.txt, holds it until the next audio sample
// and checks the bus response, the interrupt and both mixed channels.

`timescale 1ns/1ns

`include "a2_card_defines.svh"

module tb_a2_card_top;

    localparam int AUDIO_DIV = `AUDIO_DIV_DEFAULT;
    localparam int WAIT_LIMIT = 4 * AUDIO_DIV;

    logic a2bus_if;
    logic rst_n_i;
    a2_card_pkg::a2_data_t bus_data_i, ssc_data_i, ssp_data_i, mb_data_i, data_out_o;
    logic ssc_rd_i, ssc_irq_n_i, ssp_rd_i, ssp_irq_n_i, mb_rd_i, mb_irq_n_i, speaker_i;
    a2_card_pkg::card_audio_t ssp_audio_i, mb_audio_l_i, mb_audio_r_i;
    a2_card_pkg::mix_sample_t glu_audio_l_i, glu_audio_r_i, sample_l_o, sample_r_o;
    logic data_out_en_o, irq_n_o, sample_valid_o;

    // One pattern as read from the file
    a2_card_pkg::a2_data_t p_bus, p_ssc_d, p_ssp_d, p_mb_d, e_data;
    logic p_ssc_rd, p_ssc_irq, p_ssp_rd, p_ssp_irq, p_mb_rd, p_mb_irq, p_spk, e_en, e_irq;
    a2_card_pkg::card_audio_t p_ssp_a, p_mb_l, p_mb_r;
    a2_card_pkg::mix_sample_t p_glu_l, p_glu_r, e_l, e_r;

    int    fd;
    int    fields;
    int    idx;
    string line;

    // Sample period monitor state
    int   since_pulse = 0;
    int   pulses_seen = 0;
    logic last_valid = 1'b0;

    a2_card_top #(.AUDIO_DIV(AUDIO_DIV)) a2_card_top_inst (.*);

    always #4 a2bus_if = ~a2bus_if;

    task automatic stop_on_error();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        stop_on_error();
    endtask

    task automatic check_data(input string name, input a2_card_pkg::a2_data_t act,
                              input a2_card_pkg::a2_data_t exp);
        if (act !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, act, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, act, exp);
            stop_on_error();
        end
    endtask

    task automatic check_sample(input string name, input a2_card_pkg::mix_sample_t act,
                                input a2_card_pkg::mix_sample_t exp);
        if (act !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, act, exp);
            stop_on_error();
        end
    endtask

    // Channel sum from the mix rule wrapped to 16 bits
    function automatic a2_card_pkg::mix_sample_t rule_mix(input a2_card_pkg::mix_sample_t glu,
            input a2_card_pkg::card_audio_t ssp, input a2_card_pkg::card_audio_t mb,
            input logic spk);
        logic [31:0] total;
        total = {16'b0, glu} + (32'(ssp) << `CARD_AUDIO_SHIFT)
              + (32'(mb) << `CARD_AUDIO_SHIFT) + (32'(spk) << `SPEAKER_SHIFT);
        return total[15:0];
    endfunction

    task automatic verify_pattern_rules();
        a2_card_pkg::a2_data_t want;
        want = p_ssc_rd ? p_ssc_d : p_ssp_rd ? p_ssp_d : p_mb_rd ? p_mb_d : p_bus;
        if (want !== e_data || e_en !== (p_ssc_rd | p_ssp_rd | p_mb_rd) ||
            e_irq !== (p_ssc_irq & p_ssp_irq & p_mb_irq) ||
            e_l !== rule_mix(p_glu_l, p_ssp_a, p_mb_l, p_spk) ||
            e_r !== rule_mix(p_glu_r, p_ssp_a, p_mb_r, p_spk)) begin
            report_failure($sformatf("Pattern %0d in the file breaks the bus or mix rules",
                                     idx));
        end
    endtask

    task automatic apply_pattern();
        @(posedge a2bus_if);
        bus_data_i    <= p_bus;
        ssc_rd_i      <= p_ssc_rd;
        ssc_data_i    <= p_ssc_d;
        ssc_irq_n_i   <= p_ssc_irq;
        ssp_rd_i      <= p_ssp_rd;
        ssp_data_i    <= p_ssp_d;
        ssp_irq_n_i   <= p_ssp_irq;
        mb_rd_i       <= p_mb_rd;
        mb_data_i     <= p_mb_d;
        mb_irq_n_i    <= p_mb_irq;
        speaker_i     <= p_spk;
        ssp_audio_i   <= p_ssp_a;
        mb_audio_l_i  <= p_mb_l;
        mb_audio_r_i  <= p_mb_r;
        glu_audio_l_i <= p_glu_l;
        glu_audio_r_i <= p_glu_r;
    endtask

    task automatic wait_for_sample();
        int cycles;
        cycles = 0;
        @(negedge a2bus_if);
        while (sample_valid_o !== 1'b1) begin
            cycles++;
            if (cycles >= WAIT_LIMIT) begin
                report_failure($sformatf("sample_valid_o never came within %0d cycles",
                                         WAIT_LIMIT));
            end
            @(negedge a2bus_if);
        end
    endtask

    // Pulses exactly AUDIO_DIV cycles apart and one cycle wide
    always @(negedge a2bus_if) begin
        if (rst_n_i) begin
            since_pulse = since_pulse + 1;
            if (sample_valid_o === 1'b1) begin
                if (last_valid) begin
                    report_failure("sample_valid_o stayed high for more than one cycle");
                end else if (pulses_seen > 0 && since_pulse != AUDIO_DIV) begin
                    report_failure($sformatf("sample_valid_o pulses were %0d cycles apart",
                                             since_pulse));
                end
                pulses_seen = pulses_seen + 1;
                since_pulse = 0;
            end
            last_valid = sample_valid_o;
        end
    end

    initial begin
        a2bus_if      = 1'b0;
        rst_n_i       = 1'b0;
        bus_data_i    = '0;
        ssc_rd_i      = 1'b0;
        ssc_data_i    = '0;
        ssc_irq_n_i   = 1'b1;
        ssp_rd_i      = 1'b0;
        ssp_data_i    = '0;
        ssp_irq_n_i   = 1'b1;
        mb_rd_i       = 1'b0;
        mb_data_i     = '0;
        mb_irq_n_i    = 1'b1;
        speaker_i     = 1'b0;
        ssp_audio_i   = '0;
        mb_audio_l_i  = '0;
        mb_audio_r_i  = '0;
        glu_audio_l_i = '0;
        glu_audio_r_i = '0;
        idx           = 0;

        repeat (4) @(posedge a2bus_if);
        rst_n_i <= 1'b1;

        // Idle state straight after reset
        @(negedge a2bus_if);
        check_flag("data_out_en_o", data_out_en_o, 1'b0);
        check_flag("irq_n_o", irq_n_o, 1'b1);
        check_flag("sample_valid_o", sample_valid_o, 1'b0);
        check_data("data_out_o", data_out_o, '0);
        check_sample("sample_l_o", sample_l_o, '0);
        check_sample("sample_r_o", sample_r_o, '0);

        fd = $fopen("tests/card_mix_patterns.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open tests/card_mix_patterns.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line,
                             "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             p_bus, p_ssc_rd, p_ssc_d, p_ssc_irq, p_ssp_rd, p_ssp_d, p_ssp_irq,
                             p_mb_rd, p_mb_d, p_mb_irq, p_spk, p_ssp_a, p_mb_l, p_mb_r,
                             p_glu_l, p_glu_r, e_data, e_en, e_irq, e_l, e_r);
            if (fields != 21) begin
                report_failure($sformatf("Pattern %0d has %0d fields instead of 21",
                                         idx, fields));
            end
            verify_pattern_rules();
            apply_pattern();
            // Input register, then mux and mixer, then the capture stage
            repeat (3) @(posedge a2bus_if);
            wait_for_sample();
            check_data("data_out_o", data_out_o, e_data);
            check_flag("data_out_en_o", data_out_en_o, e_en);
            check_flag("irq_n_o", irq_n_o, e_irq);
            check_sample("sample_l_o", sample_l_o, e_l);
            check_sample("sample_r_o", sample_r_o, e_r);
            idx++;
        end
        $fclose(fd);

        if (idx == 0) begin
            report_failure("The pattern file held no patterns");
        end else if (pulses_seen < 2) begin
            report_failure("Too few sample_valid_o pulses to check the sample rate");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== tests/card_mix_patterns.txt ====
# bus ssc_rd ssc_d ssc_irq ssp_rd ssp_d ssp_irq mb_rd mb_d mb_irq spk ssp_a mb_l mb_r glu_l glu_r
# then expected: data en irq sample_l sample_r (all hex)
5A 0 11 1 0 22 1 0 33 1 0 000 000 000 0000 0000 5A 0 1 0000 0000
5A 1 11 1 0 22 1 0 33 1 0 000 000 000 0000 0000 11 1 1 0000 0000
5A 0 11 1 1 22 1 0 33 1 0 000 000 000 0000 0000 22 1 1 0000 0000
5A 0 11 1 0 22 1 1 33 1 0 000 000 000 0000 0000 33 1 1 0000 0000
5A 1 11 1 1 22 1 0 33 1 0 000 000 000 0000 0000 11 1 1 0000 0000
5A 0 11 1 1 22 1 1 33 1 0 000 000 000 0000 0000 22 1 1 0000 0000
5A 1 11 1 0 22 1 1 33 1 0 000 000 000 0000 0000 11 1 1 0000 0000
5A 1 11 1 1 22 1 1 33 1 0 000 000 000 0000 0000 11 1 1 0000 0000
A5 0 11 1 0 22 1 0 33 1 0 000 000 000 0000 0000 A5 0 1 0000 0000
00 0 11 0 0 22 1 0 33 1 0 000 000 000 0000 0000 00 0 0 0000 0000
00 0 11 1 0 22 0 0 33 1 0 000 000 000 0000 0000 00 0 0 0000 0000
00 0 11 1 0 22 1 0 33 0 0 000 000 000 0000 0000 00 0 0 0000 0000
00 0 11 0 0 22 1 0 33 0 0 000 000 000 0000 0000 00 0 0 0000 0000
00 0 11 0 0 22 0 0 33 0 0 000 000 000 0000 0000 00 0 0 0000 0000
00 0 11 1 0 22 1 0 33 1 0 000 000 000 0000 0000 00 0 1 0000 0000
00 0 00 1 0 00 1 0 00 1 1 000 000 000 0000 0000 00 0 1 1000 1000
00 0 00 1 0 00 1 0 00 1 0 155 000 000 0000 0000 00 0 1 0AA8 0AA8
00 0 00 1 0 00 1 0 00 1 0 000 0FF 200 0000 0000 00 0 1 07F8 1000
00 0 00 1 0 00 1 0 00 1 0 000 000 000 1234 F000 00 0 1 1234 F000
00 0 00 1 0 00 1 0 00 1 1 155 0FF 200 1234 F000 00 0 1 34D4 1AA8
00 0 00 1 0 00 1 0 00 1 1 3FF 3FF 3FF 7FFF FFFF 00 0 1 CFEF 4FEF
00 0 00 1 0 00 1 0 00 1 0 001 002 000 8000 8001 00 0 1 8018 8009
C3 0 11 1 1 22 0 0 33 1 0 010 020 030 0100 FF00 22 1 0 0280 0100
00 1 7E 1 1 22 1 1 33 0 1 000 000 000 0000 0000 7E 1 0 1000 1000
00 0 00 1 0 00 1 0 00 1 0 000 000 000 0000 0000 00 0 1 0000 0000

// ==== tb.f ====
+incdir+rtl
rtl/a2_card_pkg.sv
rtl/a2_card_ifs.sv
rtl/card_input_regs.sv
rtl/bus_response_mux.sv
rtl/audio_mixer.sv
rtl/audio_sample_out.sv
rtl/a2_card_top.sv
tests/tb_a2_card_top.sv

// ==== Bender.yml ====
package:
  name: a2_card

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/a2_card_pkg.sv
      - rtl/a2_card_ifs.sv
      - rtl/card_input_regs.sv
      - rtl/bus_response_mux.sv
      - rtl/audio_mixer.sv
      - rtl/audio_sample_out.sv
      - rtl/a2_card_top.sv
  - target: test
    files:
      - tests/tb_a2_card_top.sv
